// ==== exec_cluster.f ====
verilog/core_types_pkg.sv
verilog/alu_op_pkg.sv
verilog/exers.sv
verilog/scalu.sv
verilog/mcalu.sv
verilog/wb_arbiter.sv
verilog/exec_cluster.sv
sim/exec_cluster_properties.sv
sim/tb_exec_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute cluster testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f exec_cluster.f \
  --top-module tb_exec_cluster -Mdir obj_dir -o sim_exec_cluster > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_exec_cluster > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  exit 1
fi
exit 0

// ==== sim/tb_exec_cluster.sv ====
// Testbench for the execute cluster with random dispatch and a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;

  localparam int DW = core_types_pkg::DATA_W;
  localparam int TW = core_types_pkg::ROBID_W;
  localparam int STALL_TIMEOUT = 500;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int QUIET_CYCLES  = 40;
  localparam int FILL_LIMIT    = 64;

  logic clk, rst_n, rename_exers_write, rename_op1ready, rename_op2ready, rob_flush;
  logic [core_types_pkg::OP_W-1:0] rename_op;
  logic [TW-1:0]                   rename_robid;
  logic [core_types_pkg::RD_W-1:0] rename_rd;
  logic [DW-1:0]                   rename_op1, rename_op2;
  wire                             exers_stall, wb_valid, wb_error;
  wire  [TW-1:0]                   wb_robid;
  wire  [core_types_pkg::RD_W-1:0] wb_rd;
  wire  [DW-1:0]                   wb_result;

  // Model state indexed by ROB tag
  bit            issued [128];
  bit            seen [128];
  bit            poisoned [128];
  bit            wakes [128];
  bit            exp_err [128];
  logic [DW-1:0] exp_val [128];
  logic [5:0]    exp_rd [128];
  logic [TW-1:0] group_tags [$];
  logic [TW-1:0] next_tag;
  logic [4:0]    op_table [14];
  int            outstanding, errors, checks;
  bit            saw_full;

  exec_cluster #(.RS_ENTRIES(32), .MC_LATENCY(4)) dut (.*);

  always #20 clk = ~clk;

  task automatic check_value(input string what, input logic [DW-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0d ns: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  // Returns {error, value} straight from the opcode definitions
  function automatic logic [DW:0] model_result(input logic [4:0] op, input logic [DW-1:0] a, b);
    logic [2*DW-1:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      alu_op_pkg::OP_ADD:   return {1'b0, a + b};
      alu_op_pkg::OP_SUB:   return {1'b0, a - b};
      alu_op_pkg::OP_AND:   return {1'b0, a & b};
      alu_op_pkg::OP_OR:    return {1'b0, a | b};
      alu_op_pkg::OP_XOR:   return {1'b0, a ^ b};
      alu_op_pkg::OP_SLL:   return {1'b0, a << b[4:0]};
      alu_op_pkg::OP_SRL:   return {1'b0, a >> b[4:0]};
      alu_op_pkg::OP_SRA:   return {1'b0, DW'($signed(a) >>> b[4:0])};
      alu_op_pkg::OP_SLT:   return {32'b0, $signed(a) < $signed(b)};
      alu_op_pkg::OP_SLTU:  return {32'b0, a < b};
      alu_op_pkg::OP_MUL:   return {1'b0, prod[DW-1:0]};
      alu_op_pkg::OP_MULHU: return {1'b0, prod[2*DW-1:DW]};
      alu_op_pkg::OP_DIVU:  return (b == 0) ? {1'b1, 32'hffff_ffff} : {1'b0, a / b};
      alu_op_pkg::OP_REMU:  return (b == 0) ? {1'b1, a} : {1'b0, a % b};
      default:              return '0;
    endcase
  endfunction

  task automatic watch_writeback();
    forever begin
      @(negedge clk);
      if (exers_stall) saw_full = 1'b1;
      if (rst_n && wb_valid) begin
        if (!issued[wb_robid]) begin
          $display("Writeback of ROB tag %0d that is not in flight at %0d ns", wb_robid, $time);
          errors++;
        end else if (seen[wb_robid]) begin
          $display("ROB tag %0d written back twice at %0d ns", wb_robid, $time);
          errors++;
        end else begin
          seen[wb_robid] = 1'b1;
          if (!poisoned[wb_robid]) begin
            outstanding--;
            check_value($sformatf("tag %0d result", wb_robid), wb_result, exp_val[wb_robid]);
            check_value($sformatf("tag %0d error", wb_robid), 32'(wb_error),
                        32'(exp_err[wb_robid]));
            check_value($sformatf("tag %0d rd", wb_robid), 32'(wb_rd), 32'(exp_rd[wb_robid]));
          end
        end
      end
    end
  endtask

  task automatic wait_space();
    int cnt;
    cnt = 0;
    while (exers_stall) begin
      rename_exers_write = 1'b0;
      @(negedge clk);
      cnt++;
      if (cnt > STALL_TIMEOUT) abort_run("exers_stall never dropped");
    end
  endtask

  // Producer already done gives a ready value, otherwise a tag
  task automatic resolve_tag(input logic [TW-1:0] t, output bit rdy, output logic [DW-1:0] v,
                             output logic [DW-1:0] m, output bit p);
    logic [DW-1:0] noise;
    noise = $urandom;
    rdy = 1'b0;
    v = {noise[DW-1:TW], t};
    m = exp_val[t];
    p = poisoned[t] || !wakes[t];
    if (!p && seen[t]) begin
      rdy = 1'b1;
      v = exp_val[t];
    end
  endtask

  task automatic pick_operand(input bit may_tag, output bit rdy, output logic [DW-1:0] v,
                              output logic [DW-1:0] m, output bit p);
    if (may_tag && group_tags.size() > 0 && $urandom % 3 == 0) begin
      resolve_tag(group_tags[$urandom % group_tags.size()], rdy, v, m, p);
    end else begin
      rdy = 1'b1;
      v = ($urandom % 6 == 0) ? '0 : $urandom;
      m = v;
      p = 1'b0;
    end
  endtask

  task automatic issue_random(input bit chain);
    logic [4:0]    op;
    logic [5:0]    rd;
    bit            r1, r2, p1, p2;
    logic [DW-1:0] v1, v2, m1, m2;
    logic [DW:0]   res;
    logic [TW-1:0] tag;
    wait_space();
    op = chain ? alu_op_pkg::OP_MUL : op_table[$urandom % 14];
    rd = {!chain && ($urandom % 6 == 0), 5'($urandom)};
    if (chain && group_tags.size() > 0) resolve_tag(group_tags[$], r1, v1, m1, p1);
    else pick_operand(!chain, r1, v1, m1, p1);
    pick_operand(!chain, r2, v2, m2, p2);
    tag = next_tag;
    next_tag = next_tag + 1'b1;
    res = model_result(op, m1, m2);
    issued[tag] = 1'b1;
    seen[tag] = 1'b0;
    poisoned[tag] = p1 | p2;
    exp_err[tag] = res[DW];
    exp_val[tag] = res[DW-1:0];
    exp_rd[tag] = rd;
    wakes[tag] = !res[DW] && !rd[5];
    if (!(p1 | p2)) outstanding++;
    group_tags.push_back(tag);
    rename_exers_write = 1'b1;
    rename_op = op;
    rename_robid = tag;
    rename_rd = rd;
    rename_op1ready = r1;
    rename_op1 = v1;
    rename_op2ready = r2;
    rename_op2 = v2;
    @(negedge clk);
    rename_exers_write = 1'b0;
  endtask

  // Dependent multiplies until every entry is valid
  task automatic fill_station();
    int cnt;
    cnt = 0;
    while (!exers_stall) begin
      issue_random(1'b1);
      cnt++;
      if (cnt > FILL_LIMIT) abort_run("exers_stall never rose while filling the station");
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (outstanding != 0) begin
      @(negedge clk);
      cnt++;
      if (cnt > DRAIN_TIMEOUT) abort_run("expected writebacks never arrived");
    end
    // Consumers of non-waking producers must stay parked
    cnt = 0;
    while (cnt < QUIET_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    foreach (group_tags[i]) begin
      if (poisoned[group_tags[i]] && seen[group_tags[i]]) begin
        $display("ROB tag %0d wrote back without a woken operand", group_tags[i]);
        errors++;
      end
    end
  endtask

  task automatic do_flush();
    rob_flush = 1'b1;
    @(negedge clk);
    rob_flush = 1'b0;
    foreach (issued[i]) begin
      issued[i] = 1'b0;
      seen[i] = 1'b0;
      poisoned[i] = 1'b0;
    end
    outstanding = 0;
    group_tags.delete();
    check_value("exers_stall after flush", 32'(exers_stall), 32'd0);
  endtask

  initial begin
    op_table = '{alu_op_pkg::OP_ADD, alu_op_pkg::OP_SUB, alu_op_pkg::OP_AND, alu_op_pkg::OP_OR,
                 alu_op_pkg::OP_XOR, alu_op_pkg::OP_SLL, alu_op_pkg::OP_SRL, alu_op_pkg::OP_SRA,
                 alu_op_pkg::OP_SLT, alu_op_pkg::OP_SLTU, alu_op_pkg::OP_MUL,
                 alu_op_pkg::OP_MULHU, alu_op_pkg::OP_DIVU, alu_op_pkg::OP_REMU};
    void'($urandom(32'h6b836e9b));
    clk = 1'b0;
    rst_n = 1'b0;
    rob_flush = 1'b0;
    rename_exers_write = 1'b0;
    rename_op = '0;
    rename_robid = '0;
    rename_rd = '0;
    rename_op1ready = 1'b0;
    rename_op1 = '0;
    rename_op2ready = 1'b0;
    rename_op2 = '0;
    next_tag = '0;
    outstanding = 0;
    errors = 0;
    checks = 0;
    saw_full = 1'b0;
    fork
      watch_writeback();
    join_none
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Random groups with dependencies, drained then flushed
    repeat (10) begin
      repeat (24) issue_random(1'b0);
      wait_drain();
      do_flush();
    end

    // Flush with work in flight
    repeat (16) issue_random(1'b0);
    do_flush();

    // Flush a full station, then a clean group
    fill_station();
    do_flush();
    repeat (24) issue_random(1'b0);
    wait_drain();
    do_flush();

    // Serial multiply chain fills the station
    saw_full = 1'b0;
    repeat (48) issue_random(1'b1);
    check_value("station reached full", 32'(saw_full), 32'd1);
    wait_drain();
    check_value("exers_stall after drain", 32'(exers_stall), 32'd0);
    do_flush();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/exec_cluster_properties.sv ====
// Concurrent checks on issue steering, reset state and writeback after flush
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_properties (
  input wire                             clk,
  input wire                             rst_n,
  input wire                             rob_flush,
  input wire                             exers_stall,
  input wire                             wb_valid,
  input wire                             scalu0_issue,
  input wire                             scalu1_issue,
  input wire                             mcalu0_issue,
  input wire                             mcalu1_issue,
  input wire [core_types_pkg::OP_W-1:0]  exers_op
);

  wire [3:0] issue_vec = {mcalu1_issue, mcalu0_issue, scalu1_issue, scalu0_issue};

  one_issue_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(issue_vec))
    else $error("more than one issue strobe high");

  // Mul/div must never land on a single-cycle ALU
  no_mc_op_on_scalu: assert property (@(posedge clk) disable iff (!rst_n)
    (scalu0_issue || scalu1_issue) |-> !exers_op[alu_op_pkg::OP_MC_BIT])
    else $error("multi-cycle opcode issued to an scalu");

  quiet_after_reset: assert property (@(posedge clk)
    !rst_n |=> (!wb_valid && !exers_stall && issue_vec == 4'b0))
    else $error("outputs not idle in the cycle after reset");

  no_wb_after_flush: assert property (@(posedge clk)
    (rst_n && rob_flush) |=> !wb_valid)
    else $error("writeback valid in the cycle after a flush");

endmodule

bind exec_cluster exec_cluster_properties u_properties (
  .clk(clk), .rst_n(rst_n), .rob_flush(rob_flush), .exers_stall(exers_stall),
  .wb_valid(wb_valid), .scalu0_issue(scalu0_issue), .scalu1_issue(scalu1_issue),
  .mcalu0_issue(mcalu0_issue), .mcalu1_issue(mcalu1_issue), .exers_op(exers_op)
);

`default_nettype wire

// ==== verilog/exec_cluster.sv ====
// Execute cluster top joining the station, two ALUs, two mul/div units and writeback
`timescale 1ns/1ps
`default_nettype none

module exec_cluster #(
  parameter int RS_ENTRIES = 32,
  parameter int MC_LATENCY = 4
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                rename_exers_write,
  input  wire [core_types_pkg::OP_W-1:0]     rename_op,
  input  wire [core_types_pkg::ROBID_W-1:0]  rename_robid,
  input  wire [core_types_pkg::RD_W-1:0]     rename_rd,
  input  wire                                rename_op1ready,
  input  wire [core_types_pkg::DATA_W-1:0]   rename_op1,
  input  wire                                rename_op2ready,
  input  wire [core_types_pkg::DATA_W-1:0]   rename_op2,
  output wire                                exers_stall,
  input  wire                                rob_flush,
  output wire                                wb_valid,
  output wire                                wb_error,
  output wire [core_types_pkg::ROBID_W-1:0]  wb_robid,
  output wire [core_types_pkg::RD_W-1:0]     wb_rd,
  output wire [core_types_pkg::DATA_W-1:0]   wb_result
);

  // Issue fields shared by all four units
  wire [core_types_pkg::ROBID_W-1:0] exers_robid;
  wire [core_types_pkg::RD_W-1:0]    exers_rd;
  wire [core_types_pkg::DATA_W-1:0]  exers_op1;
  wire [core_types_pkg::DATA_W-1:0]  exers_op2;
  wire [core_types_pkg::OP_W-1:0]    exers_op;

  wire scalu0_issue, scalu1_issue, mcalu0_issue, mcalu1_issue;
  wire scalu0_stall, scalu1_stall, mcalu0_stall, mcalu1_stall;
  wire scalu0_grant, scalu1_grant, mcalu0_grant, mcalu1_grant;

  // Unit results toward the arbiter
  wire scalu0_fu_valid, scalu1_fu_valid, mcalu0_fu_valid, mcalu1_fu_valid;
  wire scalu0_fu_error, scalu1_fu_error, mcalu0_fu_error, mcalu1_fu_error;
  wire [core_types_pkg::ROBID_W-1:0] scalu0_fu_robid, scalu1_fu_robid;
  wire [core_types_pkg::ROBID_W-1:0] mcalu0_fu_robid, mcalu1_fu_robid;
  wire [core_types_pkg::RD_W-1:0]    scalu0_fu_rd, scalu1_fu_rd;
  wire [core_types_pkg::RD_W-1:0]    mcalu0_fu_rd, mcalu1_fu_rd;
  wire [core_types_pkg::DATA_W-1:0]  scalu0_fu_result, scalu1_fu_result;
  wire [core_types_pkg::DATA_W-1:0]  mcalu0_fu_result, mcalu1_fu_result;

  exers #(.RS_ENTRIES(RS_ENTRIES)) u_exers (.*);

  scalu u_scalu0 (
    .clk(clk), .rst_n(rst_n), .issue(scalu0_issue), .op(exers_op),
    .robid(exers_robid), .rd(exers_rd), .op1(exers_op1), .op2(exers_op2),
    .stall(scalu0_stall), .fu_valid(scalu0_fu_valid), .fu_error(scalu0_fu_error),
    .fu_robid(scalu0_fu_robid), .fu_rd(scalu0_fu_rd), .fu_result(scalu0_fu_result),
    .grant(scalu0_grant), .flush(rob_flush)
  );

  scalu u_scalu1 (
    .clk(clk), .rst_n(rst_n), .issue(scalu1_issue), .op(exers_op),
    .robid(exers_robid), .rd(exers_rd), .op1(exers_op1), .op2(exers_op2),
    .stall(scalu1_stall), .fu_valid(scalu1_fu_valid), .fu_error(scalu1_fu_error),
    .fu_robid(scalu1_fu_robid), .fu_rd(scalu1_fu_rd), .fu_result(scalu1_fu_result),
    .grant(scalu1_grant), .flush(rob_flush)
  );

  mcalu #(.MC_LATENCY(MC_LATENCY)) u_mcalu0 (
    .clk(clk), .rst_n(rst_n), .issue(mcalu0_issue), .op(exers_op),
    .robid(exers_robid), .rd(exers_rd), .op1(exers_op1), .op2(exers_op2),
    .stall(mcalu0_stall), .fu_valid(mcalu0_fu_valid), .fu_error(mcalu0_fu_error),
    .fu_robid(mcalu0_fu_robid), .fu_rd(mcalu0_fu_rd), .fu_result(mcalu0_fu_result),
    .grant(mcalu0_grant), .flush(rob_flush)
  );

  mcalu #(.MC_LATENCY(MC_LATENCY)) u_mcalu1 (
    .clk(clk), .rst_n(rst_n), .issue(mcalu1_issue), .op(exers_op),
    .robid(exers_robid), .rd(exers_rd), .op1(exers_op1), .op2(exers_op2),
    .stall(mcalu1_stall), .fu_valid(mcalu1_fu_valid), .fu_error(mcalu1_fu_error),
    .fu_robid(mcalu1_fu_robid), .fu_rd(mcalu1_fu_rd), .fu_result(mcalu1_fu_result),
    .grant(mcalu1_grant), .flush(rob_flush)
  );

  // Writeback leaves the cluster and feeds back into the station
  wb_arbiter u_wb_arbiter (.*);

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
// Fixed-priority writeback arbiter picking one unit result per cycle
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  wire                                 scalu0_fu_valid,
  input  wire                                 scalu0_fu_error,
  input  wire  [core_types_pkg::ROBID_W-1:0]  scalu0_fu_robid,
  input  wire  [core_types_pkg::RD_W-1:0]     scalu0_fu_rd,
  input  wire  [core_types_pkg::DATA_W-1:0]   scalu0_fu_result,
  input  wire                                 scalu1_fu_valid,
  input  wire                                 scalu1_fu_error,
  input  wire  [core_types_pkg::ROBID_W-1:0]  scalu1_fu_robid,
  input  wire  [core_types_pkg::RD_W-1:0]     scalu1_fu_rd,
  input  wire  [core_types_pkg::DATA_W-1:0]   scalu1_fu_result,
  input  wire                                 mcalu0_fu_valid,
  input  wire                                 mcalu0_fu_error,
  input  wire  [core_types_pkg::ROBID_W-1:0]  mcalu0_fu_robid,
  input  wire  [core_types_pkg::RD_W-1:0]     mcalu0_fu_rd,
  input  wire  [core_types_pkg::DATA_W-1:0]   mcalu0_fu_result,
  input  wire                                 mcalu1_fu_valid,
  input  wire                                 mcalu1_fu_error,
  input  wire  [core_types_pkg::ROBID_W-1:0]  mcalu1_fu_robid,
  input  wire  [core_types_pkg::RD_W-1:0]     mcalu1_fu_rd,
  input  wire  [core_types_pkg::DATA_W-1:0]   mcalu1_fu_result,
  output logic                                scalu0_grant,
  output logic                                scalu1_grant,
  output logic                                mcalu0_grant,
  output logic                                mcalu1_grant,
  output logic                                wb_valid,
  output logic                                wb_error,
  output logic [core_types_pkg::ROBID_W-1:0]  wb_robid,
  output logic [core_types_pkg::RD_W-1:0]     wb_rd,
  output logic [core_types_pkg::DATA_W-1:0]   wb_result
);

  localparam int BUS_W = 1 + core_types_pkg::ROBID_W + core_types_pkg::RD_W +
                         core_types_pkg::DATA_W;

  logic [3:0]       valid_vec;
  logic [3:0]       grant_vec;
  logic [BUS_W-1:0] bus_vec [4];
  logic [1:0]       sel;

  // Index 0 is scalu0, the highest priority
  assign valid_vec  = {mcalu1_fu_valid, mcalu0_fu_valid, scalu1_fu_valid, scalu0_fu_valid};
  assign bus_vec[0] = {scalu0_fu_error, scalu0_fu_robid, scalu0_fu_rd, scalu0_fu_result};
  assign bus_vec[1] = {scalu1_fu_error, scalu1_fu_robid, scalu1_fu_rd, scalu1_fu_result};
  assign bus_vec[2] = {mcalu0_fu_error, mcalu0_fu_robid, mcalu0_fu_rd, mcalu0_fu_result};
  assign bus_vec[3] = {mcalu1_fu_error, mcalu1_fu_robid, mcalu1_fu_rd, mcalu1_fu_result};

  always_comb begin
    sel = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (valid_vec[i]) begin
        sel = 2'(i);
      end
    end
  end

  assign grant_vec    = valid_vec & (4'b0001 << sel);
  assign scalu0_grant = grant_vec[0];
  assign scalu1_grant = grant_vec[1];
  assign mcalu0_grant = grant_vec[2];
  assign mcalu1_grant = grant_vec[3];

  assign wb_valid = |valid_vec;
  assign {wb_error, wb_robid, wb_rd, wb_result} = bus_vec[sel];

endmodule

`default_nettype wire

// ==== verilog/mcalu.sv ====
// Multiply/divide unit with a fixed multi-cycle latency and a held result
`timescale 1ns/1ps
`default_nettype none

module mcalu #(
  parameter int MC_LATENCY = 4
) (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 issue,
  input  wire  [core_types_pkg::OP_W-1:0]     op,
  input  wire  [core_types_pkg::ROBID_W-1:0]  robid,
  input  wire  [core_types_pkg::RD_W-1:0]     rd,
  input  wire  [core_types_pkg::DATA_W-1:0]   op1,
  input  wire  [core_types_pkg::DATA_W-1:0]   op2,
  output logic                                stall,
  output logic                                fu_valid,
  output logic                                fu_error,
  output logic [core_types_pkg::ROBID_W-1:0]  fu_robid,
  output logic [core_types_pkg::RD_W-1:0]     fu_rd,
  output logic [core_types_pkg::DATA_W-1:0]   fu_result,
  input  wire                                 grant,
  input  wire                                 flush
);

  localparam int DW    = core_types_pkg::DATA_W;
  localparam int CNT_W = $clog2(MC_LATENCY + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_DONE
  } state_e;

  state_e                          state;
  logic [CNT_W-1:0]                count;
  logic [core_types_pkg::OP_W-1:0] op_q;
  logic [DW-1:0]                   op1_q;
  logic [DW-1:0]                   op2_q;
  logic [2*DW-1:0]                 product;
  logic [DW-1:0]                   result_d;
  logic                            error_d;
  logic                            div_zero;
  logic                            finish;

  assign product  = op1_q * op2_q;
  assign div_zero = (op2_q == '0);
  assign finish   = (state == ST_BUSY) && (count == '0);

  always_comb begin
    error_d = 1'b0;
    case (alu_op_pkg::alu_op_e'(op_q))
      alu_op_pkg::OP_MUL:   result_d = product[DW-1:0];
      alu_op_pkg::OP_MULHU: result_d = product[2*DW-1:DW];
      alu_op_pkg::OP_DIVU: begin
        error_d  = div_zero;
        result_d = div_zero ? '1 : op1_q / op2_q;
      end
      alu_op_pkg::OP_REMU: begin
        error_d  = div_zero;
        result_d = div_zero ? op1_q : op1_q % op2_q;
      end
      // Single-cycle ops overflowing from the ALUs
      default: result_d = alu_op_pkg::sc_result(alu_op_pkg::alu_op_e'(op_q), op1_q, op2_q);
    endcase
  end

  // Counts MC_LATENCY edges from issue to DONE
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      state <= ST_IDLE;
      count <= '0;
    end else if (issue) begin
      state <= ST_BUSY;
      count <= CNT_W'(MC_LATENCY - 1);
    end else if (state == ST_BUSY) begin
      if (count == '0) begin
        state <= ST_DONE;
      end else begin
        count <= count - 1'b1;
      end
    end else if (grant) begin
      state <= ST_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      op_q     <= op;
      op1_q    <= op1;
      op2_q    <= op2;
      fu_robid <= robid;
      fu_rd    <= rd;
    end
    if (finish) begin
      fu_result <= result_d;
      fu_error  <= error_d;
    end
  end

  assign fu_valid = (state == ST_DONE);
  assign stall    = (state == ST_BUSY) | (fu_valid & ~grant);

endmodule

`default_nettype wire

// ==== verilog/scalu.sv ====
// Single-cycle integer ALU with one registered result held until granted
`timescale 1ns/1ps
`default_nettype none

module scalu (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 issue,
  input  wire  [core_types_pkg::OP_W-1:0]     op,
  input  wire  [core_types_pkg::ROBID_W-1:0]  robid,
  input  wire  [core_types_pkg::RD_W-1:0]     rd,
  input  wire  [core_types_pkg::DATA_W-1:0]   op1,
  input  wire  [core_types_pkg::DATA_W-1:0]   op2,
  output logic                                stall,
  output logic                                fu_valid,
  output logic                                fu_error,
  output logic [core_types_pkg::ROBID_W-1:0]  fu_robid,
  output logic [core_types_pkg::RD_W-1:0]     fu_rd,
  output logic [core_types_pkg::DATA_W-1:0]   fu_result,
  input  wire                                 grant,
  input  wire                                 flush
);

  // Issue only arrives when empty or when the held result leaves this cycle
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      fu_valid <= 1'b0;
    end else if (issue) begin
      fu_valid <= 1'b1;
    end else if (grant) begin
      fu_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      fu_robid  <= robid;
      fu_rd     <= rd;
      fu_result <= alu_op_pkg::sc_result(alu_op_pkg::alu_op_e'(op), op1, op2);
    end
  end

  // No single-cycle op can fail
  assign fu_error = 1'b0;
  assign stall    = fu_valid & ~grant;

endmodule

`default_nettype wire

// ==== verilog/exers.sv ====
// Reservation station holding renamed ops until ready, then issuing to a free unit
`timescale 1ns/1ps
`default_nettype none

module exers #(
  parameter int RS_ENTRIES = 32
) (
  input  wire                                 clk,
  input  wire                                 rst_n,
  // Rename side
  input  wire                                 rename_exers_write,
  input  wire  [core_types_pkg::OP_W-1:0]     rename_op,
  input  wire  [core_types_pkg::ROBID_W-1:0]  rename_robid,
  input  wire  [core_types_pkg::RD_W-1:0]     rename_rd,
  input  wire                                 rename_op1ready,
  input  wire  [core_types_pkg::DATA_W-1:0]   rename_op1,
  input  wire                                 rename_op2ready,
  input  wire  [core_types_pkg::DATA_W-1:0]   rename_op2,
  output logic                                exers_stall,
  // Shared issue fields
  output logic [core_types_pkg::ROBID_W-1:0]  exers_robid,
  output logic [core_types_pkg::RD_W-1:0]     exers_rd,
  output logic [core_types_pkg::DATA_W-1:0]   exers_op1,
  output logic [core_types_pkg::DATA_W-1:0]   exers_op2,
  output logic [core_types_pkg::OP_W-1:0]     exers_op,
  output logic                                scalu0_issue,
  output logic                                scalu1_issue,
  output logic                                mcalu0_issue,
  output logic                                mcalu1_issue,
  input  wire                                 scalu0_stall,
  input  wire                                 scalu1_stall,
  input  wire                                 mcalu0_stall,
  input  wire                                 mcalu1_stall,
  // Writeback bus
  input  wire                                 wb_valid,
  input  wire                                 wb_error,
  input  wire  [core_types_pkg::ROBID_W-1:0]  wb_robid,
  input  wire  [core_types_pkg::RD_W-1:0]     wb_rd,
  input  wire  [core_types_pkg::DATA_W-1:0]   wb_result,
  input  wire                                 rob_flush
);

  localparam int IDX_W = $clog2(RS_ENTRIES);
  localparam int TAG_W = core_types_pkg::ROBID_W;

  logic [RS_ENTRIES-1:0]              rs_valid;
  logic [RS_ENTRIES-1:0]              rs_op1ready;
  logic [RS_ENTRIES-1:0]              rs_op2ready;
  logic [core_types_pkg::OP_W-1:0]    rs_op [RS_ENTRIES];
  logic [TAG_W-1:0]                   rs_robid [RS_ENTRIES];
  logic [core_types_pkg::RD_W-1:0]    rs_rd [RS_ENTRIES];
  logic [core_types_pkg::DATA_W-1:0]  rs_op1 [RS_ENTRIES];
  logic [core_types_pkg::DATA_W-1:0]  rs_op2 [RS_ENTRIES];

  logic [RS_ENTRIES-1:0] ready_vec;
  logic [IDX_W-1:0]      insert_idx;
  logic [IDX_W-1:0]      issue_idx;
  logic                  issue_valid;
  logic                  issue_fire;
  logic                  insert_fire;
  logic                  is_mc_op;
  logic                  wake_valid;
  logic                  ins_op1_hit;
  logic                  ins_op2_hit;

  // Results without a destination or with an error wake nothing
  assign wake_valid = wb_valid & ~wb_error & ~wb_rd[core_types_pkg::RD_NODEST_BIT];

  assign exers_stall = &rs_valid;
  assign insert_fire = rename_exers_write & ~exers_stall;
  assign ready_vec   = rs_valid & rs_op1ready & rs_op2ready;
  assign issue_valid = |ready_vec;

  // Producer writing back on the insert edge, catch it here or it is missed
  assign ins_op1_hit = wake_valid & ~rename_op1ready & (rename_op1[TAG_W-1:0] == wb_robid);
  assign ins_op2_hit = wake_valid & ~rename_op2ready & (rename_op2[TAG_W-1:0] == wb_robid);

  // Lowest free slot and lowest ready slot
  always_comb begin
    insert_idx = '0;
    issue_idx  = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (!rs_valid[i]) begin
        insert_idx = IDX_W'(i);
      end
      if (ready_vec[i]) begin
        issue_idx = IDX_W'(i);
      end
    end
  end

  assign exers_robid = rs_robid[issue_idx];
  assign exers_rd    = rs_rd[issue_idx];
  assign exers_op1   = rs_op1[issue_idx];
  assign exers_op2   = rs_op2[issue_idx];
  assign exers_op    = rs_op[issue_idx];
  assign is_mc_op    = rs_op[issue_idx][alu_op_pkg::OP_MC_BIT];

  // Priority scalu0, scalu1, mcalu0, mcalu1; mul/div skip the ALUs
  always_comb begin
    scalu0_issue = 1'b0;
    scalu1_issue = 1'b0;
    mcalu0_issue = 1'b0;
    mcalu1_issue = 1'b0;
    if (issue_valid) begin
      if (!is_mc_op && !scalu0_stall) begin
        scalu0_issue = 1'b1;
      end else if (!is_mc_op && !scalu1_stall) begin
        scalu1_issue = 1'b1;
      end else if (!mcalu0_stall) begin
        mcalu0_issue = 1'b1;
      end else if (!mcalu1_stall) begin
        mcalu1_issue = 1'b1;
      end
    end
  end

  assign issue_fire = scalu0_issue | scalu1_issue | mcalu0_issue | mcalu1_issue;

  always_ff @(posedge clk) begin
    if (!rst_n || rob_flush) begin
      rs_valid <= '0;
    end else begin
      if (issue_fire) begin
        rs_valid[issue_idx] <= 1'b0;
      end
      if (insert_fire) begin
        rs_valid[insert_idx] <= 1'b1;
      end
    end
  end

  // Operand capture from writeback, then the new entry
  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (wake_valid && rs_valid[i] && !rs_op1ready[i] &&
          rs_op1[i][TAG_W-1:0] == wb_robid) begin
        rs_op1ready[i] <= 1'b1;
        rs_op1[i]      <= wb_result;
      end
      if (wake_valid && rs_valid[i] && !rs_op2ready[i] &&
          rs_op2[i][TAG_W-1:0] == wb_robid) begin
        rs_op2ready[i] <= 1'b1;
        rs_op2[i]      <= wb_result;
      end
    end
    if (insert_fire) begin
      rs_op[insert_idx]       <= rename_op;
      rs_robid[insert_idx]    <= rename_robid;
      rs_rd[insert_idx]       <= rename_rd;
      rs_op1ready[insert_idx] <= rename_op1ready | ins_op1_hit;
      rs_op1[insert_idx]      <= ins_op1_hit ? wb_result : rename_op1;
      rs_op2ready[insert_idx] <= rename_op2ready | ins_op2_hit;
      rs_op2[insert_idx]      <= ins_op2_hit ? wb_result : rename_op2;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/alu_op_pkg.sv ====
// Execute opcodes, their class bit and the shared single-cycle result function
`default_nettype none

package alu_op_pkg;

  // Set for multiply/divide, which only the multi-cycle units accept
  localparam int OP_MC_BIT = 4;

  localparam int SHAMT_W = $clog2(core_types_pkg::DATA_W);

  typedef enum logic [core_types_pkg::OP_W-1:0] {
    OP_ADD   = 5'h00,
    OP_SUB   = 5'h01,
    OP_AND   = 5'h02,
    OP_OR    = 5'h03,
    OP_XOR   = 5'h04,
    OP_SLL   = 5'h05,
    OP_SRL   = 5'h06,
    OP_SRA   = 5'h07,
    OP_SLT   = 5'h08,
    OP_SLTU  = 5'h09,
    // Multi-cycle group
    OP_MUL   = 5'h10,
    OP_MULHU = 5'h11,
    OP_DIVU  = 5'h12,
    OP_REMU  = 5'h13
  } alu_op_e;

  // Used by both unit types, since any unit may run a single-cycle op
  function automatic logic [core_types_pkg::DATA_W-1:0] sc_result(
    input alu_op_e                           op,
    input logic [core_types_pkg::DATA_W-1:0] a,
    input logic [core_types_pkg::DATA_W-1:0] b
  );
    logic [core_types_pkg::DATA_W-1:0] r;
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SLL:  r = a << b[SHAMT_W-1:0];
      OP_SRL:  r = a >> b[SHAMT_W-1:0];
      OP_SRA:  r = $signed(a) >>> b[SHAMT_W-1:0];
      OP_SLT:  r = core_types_pkg::DATA_W'($signed(a) < $signed(b));
      OP_SLTU: r = core_types_pkg::DATA_W'(a < b);
      default: r = '0;
    endcase
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/core_types_pkg.sv ====
// Core-wide widths for ROB tags, register fields, operand data and opcodes
`default_nettype none

package core_types_pkg;

  // ROB tag carried by every operation and by unready operands
  localparam int ROBID_W = 7;

  // Destination register field
  localparam int RD_W = 6;

  // Set in the destination field when the operation writes no register
  localparam int RD_NODEST_BIT = 5;

  localparam int DATA_W = 32;
  localparam int OP_W = 5;

endpackage

`default_nettype wire
